// ==== hdl/core_pkg.sv ====
`default_nettype none

package core_pkg;

    localparam int alu_op_nbit = 4;
    localparam int wtg_op_nbit = 3;
    localparam int dm_op_nbit = 1;
    localparam int rc0_op_nbit = 2;

    localparam int mux_rf_reqw_nbit = 2;
    localparam int mux_alu_datay_nbit = 2;
    localparam int mux_rc0_iew_nbit = 2;
    localparam int mux_rc0_epcw_nbit = 1;

    localparam logic [alu_op_nbit-1:0] alu_add  = 4'd0;
    localparam logic [alu_op_nbit-1:0] alu_sub  = 4'd1;
    localparam logic [alu_op_nbit-1:0] alu_and  = 4'd2;
    localparam logic [alu_op_nbit-1:0] alu_or   = 4'd3;
    localparam logic [alu_op_nbit-1:0] alu_nor  = 4'd4;
    localparam logic [alu_op_nbit-1:0] alu_slt  = 4'd5;
    localparam logic [alu_op_nbit-1:0] alu_sltu = 4'd6;
    localparam logic [alu_op_nbit-1:0] alu_sll  = 4'd7;
    localparam logic [alu_op_nbit-1:0] alu_srl  = 4'd8;
    localparam logic [alu_op_nbit-1:0] alu_sra  = 4'd9;
    localparam logic [alu_op_nbit-1:0] alu_sllv = 4'd10;
    localparam logic [alu_op_nbit-1:0] alu_lui  = 4'd11;

    localparam logic [wtg_op_nbit-1:0] wtg_jno  = 3'd0; // pc+4
    localparam logic [wtg_op_nbit-1:0] wtg_j26  = 3'd1;
    localparam logic [wtg_op_nbit-1:0] wtg_j32  = 3'd2;
    localparam logic [wtg_op_nbit-1:0] wtg_beq  = 3'd3;
    localparam logic [wtg_op_nbit-1:0] wtg_bne  = 3'd4;
    localparam logic [wtg_op_nbit-1:0] wtg_bgez = 3'd5;
    localparam logic [wtg_op_nbit-1:0] wtg_irq  = 3'd6;
    localparam logic [wtg_op_nbit-1:0] wtg_iret = 3'd7;

    localparam logic [dm_op_nbit-1:0] dm_wd = 1'b0; // full word
    localparam logic [dm_op_nbit-1:0] dm_ub = 1'b1; // unsigned byte

    localparam logic [rc0_op_nbit-1:0] rc0_nop = 2'd0;
    localparam logic [rc0_op_nbit-1:0] rc0_irq = 2'd1;
    localparam logic [rc0_op_nbit-1:0] rc0_ret = 2'd2;

    localparam logic [mux_rf_reqw_nbit-1:0] mux_rf_reqw_rt = 2'd0;
    localparam logic [mux_rf_reqw_nbit-1:0] mux_rf_reqw_rd = 2'd1;
    localparam logic [mux_rf_reqw_nbit-1:0] mux_rf_reqw_31 = 2'd2;

    localparam logic [mux_alu_datay_nbit-1:0] mux_alu_datay_rfb  = 2'd0;
    localparam logic [mux_alu_datay_nbit-1:0] mux_alu_datay_exts = 2'd1;
    localparam logic [mux_alu_datay_nbit-1:0] mux_alu_datay_extz = 2'd2;

    localparam logic [mux_rc0_iew_nbit-1:0] mux_rc0_iew_rf   = 2'd0;
    localparam logic [mux_rc0_iew_nbit-1:0] mux_rc0_iew_zero = 2'd1;
    localparam logic [mux_rc0_iew_nbit-1:0] mux_rc0_iew_one  = 2'd2;

    localparam logic [mux_rc0_epcw_nbit-1:0] mux_rc0_epcw_rf = 1'b0;
    localparam logic [mux_rc0_epcw_nbit-1:0] mux_rc0_epcw_pc = 1'b1;

    localparam logic [31:0] irq_vector = 32'h0000_0100; // handler entry

    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } i;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target26;
        } j;
    } instr_t;

endpackage

`default_nettype wire

// ==== hdl/cmb_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module cmb_control (
    input wire [5:0] opcode,
    input wire [4:0] rs,
    input wire [5:0] funct,
    input wire is_irq,
    input wire is_epc,
    output logic rf_we,
    output logic [core_pkg::rc0_op_nbit-1:0] rc0_op,
    output logic rc0_ie_we,
    output logic rc0_epc_we,
    output logic [core_pkg::alu_op_nbit-1:0] alu_op,
    output logic [core_pkg::wtg_op_nbit-1:0] wtg_op,
    output logic syscall_en,
    output logic [core_pkg::dm_op_nbit-1:0] dm_op,
    output logic dm_we,
    output logic [core_pkg::mux_rf_reqw_nbit-1:0] mux_rf_req_w,
    output logic sel_rf_w_pc_4,
    output logic sel_rf_w_dm,
    output logic [core_pkg::mux_rc0_iew_nbit-1:0] mux_rc0_ie_w,
    output logic [core_pkg::mux_rc0_epcw_nbit-1:0] mux_rc0_epc_w,
    output logic [core_pkg::mux_alu_datay_nbit-1:0] mux_alu_data_y,
    output logic sel_rf_w_cp0
);
    import core_pkg::*;

    always_comb begin
        rf_we = 1'b1;
        rc0_op = rc0_nop;
        rc0_ie_we = 1'b0;
        rc0_epc_we = 1'b0;
        alu_op = alu_add;
        wtg_op = wtg_jno;
        syscall_en = 1'b0;
        dm_op = dm_wd;
        dm_we = 1'b0;
        mux_rf_req_w = mux_rf_reqw_rt;
        sel_rf_w_pc_4 = 1'b0;
        sel_rf_w_dm = 1'b0;
        mux_rc0_ie_w = mux_rc0_iew_rf;
        mux_rc0_epc_w = mux_rc0_epcw_rf;
        mux_alu_data_y = mux_alu_datay_exts;
        sel_rf_w_cp0 = 1'b0;

        if (is_irq) begin // instruction is dropped
            rc0_op = rc0_irq;
            rc0_ie_we = 1'b1;
            rc0_epc_we = 1'b1;
            mux_rc0_ie_w = mux_rc0_iew_zero;
            mux_rc0_epc_w = mux_rc0_epcw_pc;
            rf_we = 1'b0;
            wtg_op = wtg_irq;
        end else begin
            case (opcode)
                6'b000000: begin
                    mux_rf_req_w = mux_rf_reqw_rd;
                    mux_alu_data_y = mux_alu_datay_rfb;
                    case (funct)
                        6'b000000: alu_op = alu_sll;
                        6'b000010: alu_op = alu_srl;
                        6'b000011: alu_op = alu_sra;
                        6'b000100: alu_op = alu_sllv;
                        6'b001000: begin // jr
                            wtg_op = wtg_j32;
                            rf_we = 1'b0;
                        end
                        6'b001100: begin // syscall
                            syscall_en = 1'b1;
                            rf_we = 1'b0;
                        end
                        6'b100010: alu_op = alu_sub;
                        6'b100100: alu_op = alu_and;
                        6'b100101: alu_op = alu_or;
                        6'b100111: alu_op = alu_nor;
                        6'b101010: alu_op = alu_slt;
                        6'b101011: alu_op = alu_sltu;
                        default: alu_op = alu_add; // add, addu
                    endcase
                end
                6'b000001: begin // bgez
                    wtg_op = wtg_bgez;
                    rf_we = 1'b0;
                end
                6'b000010: begin // j
                    wtg_op = wtg_j26;
                    rf_we = 1'b0;
                end
                6'b000011: begin // jal
                    wtg_op = wtg_j26;
                    mux_rf_req_w = mux_rf_reqw_31;
                    sel_rf_w_pc_4 = 1'b1;
                end
                6'b000100: begin
                    wtg_op = wtg_beq;
                    rf_we = 1'b0;
                end
                6'b000101: begin
                    wtg_op = wtg_bne;
                    rf_we = 1'b0;
                end
                6'b001010: alu_op = alu_slt; // slti
                6'b001100: begin // andi
                    alu_op = alu_and;
                    mux_alu_data_y = mux_alu_datay_extz;
                end
                6'b001101: begin // ori
                    alu_op = alu_or;
                    mux_alu_data_y = mux_alu_datay_extz;
                end
                6'b001111: alu_op = alu_lui;
                6'b010000: begin
                    if (rs[4]) begin // eret
                        rc0_op = rc0_ret;
                        rc0_ie_we = 1'b1;
                        mux_rc0_ie_w = mux_rc0_iew_one;
                        rf_we = 1'b0;
                        wtg_op = wtg_iret;
                    end else if (rs[2]) begin // mtc0
                        rc0_epc_we = is_epc;
                        rc0_ie_we = !is_epc;
                        rf_we = 1'b0;
                    end else begin
                        sel_rf_w_cp0 = 1'b1; // mfc0
                    end
                end
                6'b100011: sel_rf_w_dm = 1'b1; // lw
                6'b100100: begin // lbu
                    sel_rf_w_dm = 1'b1;
                    dm_op = dm_ub;
                end
                6'b101011: begin // sw
                    dm_we = 1'b1;
                    rf_we = 1'b0;
                end
                default: alu_op = alu_add; // addi, addiu
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input wire clk,
    input wire [4:0] ra1,
    input wire [4:0] ra2,
    input wire [4:0] wa,
    input wire we,
    input wire [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);
    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1]; // $zero
    assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu (
    input wire [core_pkg::alu_op_nbit-1:0] alu_op,
    input wire [31:0] x,
    input wire [31:0] y,
    input wire [4:0] shamt,
    output logic [31:0] result
);
    import core_pkg::*;

    always_comb begin
        case (alu_op)
            alu_add:  result = x + y;
            alu_sub:  result = x - y;
            alu_and:  result = x & y;
            alu_or:   result = x | y;
            alu_nor:  result = ~(x | y);
            alu_slt:  result = {31'd0, $signed(x) < $signed(y)};
            alu_sltu: result = {31'd0, x < y};
            alu_sll:  result = y << shamt;
            alu_srl:  result = y >> shamt;
            alu_sra:  result = $unsigned($signed(y) >>> shamt);
            alu_sllv: result = y << x[4:0]; // amount from rs
            alu_lui:  result = {y[15:0], 16'd0};
            default:  result = x + y;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/where_to_go.sv ====
`timescale 1ns/100ps
`default_nettype none

module where_to_go (
    input wire [core_pkg::wtg_op_nbit-1:0] wtg_op,
    input wire [31:0] pc,
    input wire [15:0] imm16,
    input wire [25:0] target26,
    input wire [31:0] rs_val,
    input wire [31:0] rt_val,
    input wire [31:0] epc,
    output logic [31:0] next_pc
);
    import core_pkg::*;

    logic [31:0] pc_4;
    logic [31:0] br_target;

    assign pc_4 = pc + 32'd4;
    assign br_target = pc_4 + {{14{imm16[15]}}, imm16, 2'b00};

    always_comb begin
        case (wtg_op)
            wtg_j26:  next_pc = {pc_4[31:28], target26, 2'b00};
            wtg_j32:  next_pc = rs_val;
            wtg_beq:  next_pc = (rs_val == rt_val) ? br_target : pc_4;
            wtg_bne:  next_pc = (rs_val != rt_val) ? br_target : pc_4;
            wtg_bgez: next_pc = rs_val[31] ? pc_4 : br_target; // sign bit only
            wtg_irq:  next_pc = irq_vector;
            wtg_iret: next_pc = epc;
            default:  next_pc = pc_4;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/cp0_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module cp0_regs (
    input wire clk,
    input wire reset,
    input wire ie_we,
    input wire epc_we,
    input wire [core_pkg::mux_rc0_iew_nbit-1:0] mux_ie_w,
    input wire [core_pkg::mux_rc0_epcw_nbit-1:0] mux_epc_w,
    input wire [31:0] rf_val,
    input wire [31:0] pc,
    input wire is_epc,
    output logic ie,
    output logic [31:0] epc,
    output logic [31:0] rd_val
);
    import core_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            ie <= 1'b0;
        end else if (ie_we) begin
            case (mux_ie_w)
                mux_rc0_iew_zero: ie <= 1'b0;
                mux_rc0_iew_one:  ie <= 1'b1;
                default:          ie <= rf_val[0]; // status bit 0
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (epc_we) begin
            epc <= (mux_epc_w == mux_rc0_epcw_pc) ? pc : rf_val;
        end
    end

    assign rd_val = is_epc ? epc : {31'd0, ie};

endmodule

`default_nettype wire

// ==== hdl/instr_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module instr_mem #(
    parameter int imem_words = 256
) (
    input wire clk,
    input wire load_we,
    input wire [31:0] load_addr,
    input wire [31:0] load_data,
    input wire [31:0] addr,
    output logic [31:0] instr
);
    localparam int aw = $clog2(imem_words);

    logic [31:0] mem [imem_words];

    always_ff @(posedge clk) begin
        if (load_we) begin
            mem[load_addr[aw+1:2]] <= load_data;
        end
    end

    assign instr = mem[addr[aw+1:2]]; // byte offset dropped

endmodule

`default_nettype wire

// ==== hdl/data_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module data_mem #(
    parameter int dmem_words = 256
) (
    input wire clk,
    input wire we,
    input wire [core_pkg::dm_op_nbit-1:0] dm_op,
    input wire [31:0] addr,
    input wire [31:0] wd,
    output logic [31:0] rd
);
    import core_pkg::*;

    localparam int aw = $clog2(dmem_words);

    logic [31:0] mem [dmem_words];
    logic [31:0] word;
    logic [7:0] lane;

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr[aw+1:2]] <= wd;
        end
    end

    assign word = mem[addr[aw+1:2]];

    always_comb begin
        case (addr[1:0]) // little-endian lanes
            2'd0: lane = word[7:0];
            2'd1: lane = word[15:8];
            2'd2: lane = word[23:16];
            default: lane = word[31:24];
        endcase
    end

    assign rd = (dm_op == dm_ub) ? {24'd0, lane} : word;

endmodule

`default_nettype wire

// ==== hdl/mips_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_core #(
    parameter int imem_words = 256,
    parameter int dmem_words = 256
) (
    input wire clk,
    input wire reset,
    input wire load_we,
    input wire [31:0] load_addr,
    input wire [31:0] load_data,
    input wire irq,
    output logic wb_valid,
    output logic [4:0] wb_addr,
    output logic [31:0] wb_data,
    output logic halted
);
    import core_pkg::*;

    instr_t ir;
    logic [31:0] pc;
    logic [31:0] pc_4;
    logic [31:0] next_pc;
    logic is_irq;
    logic is_epc;
    logic commit;
    logic ie;
    logic [31:0] epc;
    logic [31:0] cp0_rd;
    logic [31:0] rf_a;
    logic [31:0] rf_b;
    logic [4:0] rf_wa;
    logic [31:0] rf_wd;
    logic [31:0] alu_y;
    logic [31:0] alu_result;
    logic [31:0] dm_rd;
    logic [31:0] exts;
    logic [31:0] extz;

    logic rf_we;
    logic rc0_ie_we;
    logic rc0_epc_we;
    logic [alu_op_nbit-1:0] alu_op;
    logic [wtg_op_nbit-1:0] wtg_op;
    logic syscall_en;
    logic [dm_op_nbit-1:0] dm_op;
    logic dm_we;
    logic [mux_rf_reqw_nbit-1:0] mux_rf_req_w;
    logic sel_rf_w_pc_4;
    logic sel_rf_w_dm;
    logic [mux_rc0_iew_nbit-1:0] mux_rc0_ie_w;
    logic [mux_rc0_epcw_nbit-1:0] mux_rc0_epc_w;
    logic [mux_alu_datay_nbit-1:0] mux_alu_data_y;
    logic sel_rf_w_cp0;

    assign is_irq = irq & ie & ~halted;
    assign is_epc = (ir.r.rd == 5'd14);
    assign commit = ~reset & ~halted; // no state change while loading or stopped
    assign pc_4 = pc + 32'd4;
    assign exts = {{16{ir.i.imm16[15]}}, ir.i.imm16};
    assign extz = {16'd0, ir.i.imm16};

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= 32'd0;
            halted <= 1'b0;
        end else begin
            if (!halted && !syscall_en) begin
                pc <= next_pc;
            end
            if (syscall_en) begin
                halted <= 1'b1;
            end
        end
    end

    always_comb begin
        case (mux_rf_req_w)
            mux_rf_reqw_rd: rf_wa = ir.r.rd;
            mux_rf_reqw_31: rf_wa = 5'd31; // jal link
            default:        rf_wa = ir.r.rt;
        endcase
        case (mux_alu_data_y)
            mux_alu_datay_rfb:  alu_y = rf_b;
            mux_alu_datay_extz: alu_y = extz;
            default:            alu_y = exts;
        endcase
        if (sel_rf_w_pc_4) begin
            rf_wd = pc_4;
        end else if (sel_rf_w_dm) begin
            rf_wd = dm_rd;
        end else if (sel_rf_w_cp0) begin
            rf_wd = cp0_rd;
        end else begin
            rf_wd = alu_result;
        end
    end

    assign wb_valid = rf_we & commit;
    assign wb_addr = rf_wa;
    assign wb_data = rf_wd;

    cmb_control u_control (
        .opcode(ir.r.opcode), .rs(ir.r.rs), .funct(ir.r.funct),
        .is_irq(is_irq), .is_epc(is_epc),
        .rf_we(rf_we), .rc0_op(), .rc0_ie_we(rc0_ie_we), .rc0_epc_we(rc0_epc_we),
        .alu_op(alu_op), .wtg_op(wtg_op), .syscall_en(syscall_en),
        .dm_op(dm_op), .dm_we(dm_we),
        .mux_rf_req_w(mux_rf_req_w), .sel_rf_w_pc_4(sel_rf_w_pc_4),
        .sel_rf_w_dm(sel_rf_w_dm), .mux_rc0_ie_w(mux_rc0_ie_w),
        .mux_rc0_epc_w(mux_rc0_epc_w), .mux_alu_data_y(mux_alu_data_y),
        .sel_rf_w_cp0(sel_rf_w_cp0)
    );

    reg_file u_rf (
        .clk(clk), .ra1(ir.r.rs), .ra2(ir.r.rt), .wa(rf_wa),
        .we(wb_valid), .wd(rf_wd), .rd1(rf_a), .rd2(rf_b)
    );

    alu u_alu (
        .alu_op(alu_op), .x(rf_a), .y(alu_y), .shamt(ir.r.shamt), .result(alu_result)
    );

    where_to_go u_wtg (
        .wtg_op(wtg_op), .pc(pc), .imm16(ir.i.imm16), .target26(ir.j.target26),
        .rs_val(rf_a), .rt_val(rf_b), .epc(epc), .next_pc(next_pc)
    );

    cp0_regs u_cp0 (
        .clk(clk), .reset(reset),
        .ie_we(rc0_ie_we & commit), .epc_we(rc0_epc_we & commit),
        .mux_ie_w(mux_rc0_ie_w), .mux_epc_w(mux_rc0_epc_w),
        .rf_val(rf_b), .pc(pc), .is_epc(is_epc),
        .ie(ie), .epc(epc), .rd_val(cp0_rd)
    );

    instr_mem #(.imem_words(imem_words)) u_imem (
        .clk(clk), .load_we(load_we & reset), .load_addr(load_addr),
        .load_data(load_data), .addr(pc), .instr(ir)
    );

    data_mem #(.dmem_words(dmem_words)) u_dmem (
        .clk(clk), .we(dm_we & commit), .dm_op(dm_op),
        .addr(alu_result), .wd(rf_b), .rd(dm_rd)
    );

endmodule

`default_nettype wire

// ==== bench/mips_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_core_tb;

    logic clk;
    logic reset;
    logic load_we;
    logic [31:0] load_addr;
    logic [31:0] load_data;
    logic irq;
    logic wb_valid;
    logic [4:0] wb_addr;
    logic [31:0] wb_data;
    logic halted;

    logic [31:0] stream [2048];
    logic [31:0] rand_tab [16];
    int test_ptr [16];
    int num_tests;
    int total_words;
    int errors;
    int passed;
    logic limit_ready;

    mips_core UUT (
        .clk(clk), .reset(reset), .load_we(load_we), .load_addr(load_addr),
        .load_data(load_data), .irq(irq), .wb_valid(wb_valid), .wb_addr(wb_addr),
        .wb_data(wb_data), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // opcode 3f marks a lui or ori of a random constant
    function automatic logic [31:0] expand_word(input logic [31:0] w);
        logic [4:0] rt;
        logic [31:0] r;
        rt = w[20:16];
        r = rand_tab[w[3:0]];
        if (w[31:26] != 6'h3f) return w;
        if (w[8]) return {6'b001101, rt, rt, r[15:0]};
        return {6'b001111, 5'd0, rt, r[31:16]};
    endfunction

    function automatic logic [31:0] expected_data(input logic [31:0] kind_reg,
                                                  input logic [31:0] v);
        case (kind_reg[9:8])
            2'd1: return rand_tab[v[3:0]];
            2'd2: return rand_tab[v[3:0]] & 32'hffff_0000; // lui half
            default: return v;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s is %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic run_test(input int t);
        int p;
        int n;
        int h;
        int irq_on;
        int irq_off;
        int m;
        int seen;
        int cyc;
        int err_start;
        logic expect_halt;
        p = test_ptr[t];
        n = int'(stream[p]);
        h = int'(stream[p + 1 + n]);
        err_start = errors;
        @(posedge clk);
        reset <= 1'b1;
        irq <= 1'b0;
        repeat (16) begin
            @(negedge clk);
            check_value("wb_valid", {31'd0, wb_valid}, 32'd0); // no writes while in reset
            @(posedge clk);
        end
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            load_we <= 1'b1;
            load_addr <= 32'(4 * i);
            load_data <= expand_word(stream[p + 1 + i]);
        end
        for (int i = 0; i < h; i++) begin
            @(posedge clk);
            load_we <= 1'b1;
            load_addr <= 32'h100 + 32'(4 * i); // handler entry
            load_data <= expand_word(stream[p + 2 + n + i]);
        end
        p = p + 2 + n + h;
        irq_on = int'(stream[p]);
        irq_off = int'(stream[p + 1]);
        m = int'(stream[p + 2]);
        p = p + 3;
        expect_halt = stream[p + 2 * m][0];
        @(posedge clk);
        load_we <= 1'b0;
        reset <= 1'b0;
        irq <= (irq_on <= 0 && 0 < irq_off);
        cyc = 0;
        seen = 0;
        while (cyc < 10 * (n + h)) begin
            @(negedge clk);
            if (halted) break;
            if (wb_valid) begin
                if (seen < m) begin
                    check_value("wb_addr", {27'd0, wb_addr}, {27'd0, stream[p + 2 * seen][4:0]});
                    check_value("wb_data", wb_data,
                                expected_data(stream[p + 2 * seen], stream[p + 2 * seen + 1]));
                end else begin
                    $display("test %0d: unexpected writeback to register %0d", t, wb_addr);
                    errors++;
                end
                seen++;
            end
            @(posedge clk);
            cyc++;
            irq <= (cyc >= irq_on && cyc < irq_off);
        end
        if (halted) begin
            repeat (4) begin
                @(negedge clk);
                if (wb_valid) begin
                    $display("test %0d: writeback seen after the core halted", t);
                    errors++;
                end
            end
        end
        if (halted !== expect_halt) begin
            $display("test %0d: halt state is %0b but %0b was expected", t, halted, expect_halt);
            errors++;
        end
        if (seen < m) begin
            $display("test %0d: only %0d of %0d writebacks were seen", t, seen, m);
            errors++;
        end
        if (errors == err_start) passed++;
        $display("test %0d: %0d writebacks, %s", t, seen, (errors == err_start) ? "ok" : "bad");
    endtask

    initial begin
        int p;
        reset = 1'b1;
        load_we = 1'b0;
        load_addr = 32'd0;
        load_data = 32'd0;
        irq = 1'b0;
        errors = 0;
        passed = 0;
        total_words = 0;
        limit_ready = 1'b0;
        $readmemh("bench/core_tests.txt", stream);
        rand_tab[0] = xorshift(32'd78);
        for (int k = 1; k < 16; k++) rand_tab[k] = xorshift(rand_tab[k - 1]);
        num_tests = int'(stream[0]);
        p = 1;
        for (int t = 0; t < num_tests; t++) begin // index each test block
            test_ptr[t] = p;
            total_words += int'(stream[p]);
            p += 1 + int'(stream[p]);
            total_words += int'(stream[p]);
            p += 3 + int'(stream[p]);
            p += 2 * int'(stream[p]) + 2;
        end
        limit_ready = 1'b1;
        for (int t = 0; t < num_tests; t++) run_test(t);
        $display("%0d tests, %0d passed, %0d errors", num_tests, passed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        wait (limit_ready);
        repeat (20 * total_words) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", 20 * total_words);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mips_core.f ====
hdl/core_pkg.sv
hdl/cmb_control.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/where_to_go.sv
hdl/cp0_regs.sv
hdl/instr_mem.sv
hdl/data_mem.sv
hdl/mips_core.sv
bench/mips_core_tb.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log &&
    verilator --binary --timing --top-module mips_core_tb -f mips_core.f -o mips_sim &&
    ./obj_dir/mips_sim | tee sim.log
grep -qF '*** TEST PASSED ***' sim.log && echo "run.sh: simulation passed" ||
    { echo "run.sh: simulation failed"; exit 1; }

// ==== bench/core_tests.txt ====
// test: nwords, words at 0x000; nhandler, words at 0x100; irq_on irq_off (cycles, 0 0 = none)
// then nwb, pairs (kind<<8 | reg, data) with kind 1 = xorshift value k, 2 = its upper half; halt
// opcode 3f words: lui (bit 8 = 0) or ori (bit 8 = 1) of xorshift value k, rt in bits 20:16
4
// alu, shifts and immediates
12 20010005 2002FFFD 00221820 00222022 00222824 00223025 00223827 0041402A
   0041482B 00015100 00025F02 00026043 00616804 284EFFFE 304FFFF0 34108001 3C111234 0000000C
0 0 0
11 1 00000005 2 FFFFFFFD 3 00000002 4 00000008 5 00000005 6 FFFFFFFD 7 00000002 8 00000001
   9 00000000 A 00000050 B 0000000F C FFFFFFFE D 00000014 E 00000001 F 0000FFF0 10 00008001
   11 12340000
1
// sw and lw of random words, lbu of every byte lane
10 FC010000 FC010100 AC010010 8C020010 FC030001 FC030101 AC030014 8C040014
   3C058899 34A5AABB AC050018 90060018 90070019 9008001A 9009001B 0000000C
0 0 0
C 201 0 101 0 102 0 203 1 103 1 104 1 5 88990000 5 8899AABB 6 BB 7 AA 8 99 9 88
1
// beq, bne, bgez taken and not taken, jal and jr
12 20010001 10200001 20020002 10210001 20030003 14200001 20040004 14210001
   20050005 04410001 20060006 2007FFFF 04E10001 0C000010 20080008 0000000C 20090009 03E00008
0 0 0
7 1 1 2 2 5 5 7 FFFFFFFF 1F 38 9 9 8 8
1
// cp0 round trip, irq ignored with ie low, then taken and returned from
8 20011234 40817000 40027000 40036000 20040001 40846000 20050005 0000000C
3 40067000 40076000 42000018
2 8
7 1 1234 2 1234 3 0 4 1 6 18 7 0 5 5
1
